/* flist.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/link_bit.sv
verilog/mem_access_ctrl.sv
verilog/load_align.sv
verilog/mem_wb_reg.sv
verilog/mem_stage.sv
test/clk_gen.sv
test/tb_mem_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Test completed successfully

SRCS    := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS    := $(wildcard verilog/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	    echo "simulation passed"; \
	else \
	    echo "simulation FAILED, see $(LOG)"; \
	    exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module tb_mem_stage;

    localparam int MAX_CYCLES = 400;
    localparam int SEED       = 39272;

    logic                   clk;
    logic                   arst_n;
    mem_pkg::ex_mem_t       ex;
    mem_pkg::dbus_req_t     dbus;
    mem_pkg::wb_t           wb;
    logic [`MEM_WORD_W-1:0] rdata;

    logic [7:0]             mem  [0:63];   // written by the DUT bus
    logic [7:0]             gold [0:63];   // written by the expected bus
    mem_pkg::dbus_req_t     exp_bus;
    mem_pkg::wb_t           exp_wb_pend;   // result of the op now on the bus
    mem_pkg::wb_t           exp_wb;
    logic                   link_m;
    int                     cycles = 0;

    clk_gen #(.PERIOD_NS(40), .RST_CYCLES(16)) u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    mem_stage UUT (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .ex_i         (ex),
        .dbus_rdata_i (rdata),
        .dbus_o       (dbus),
        .wb_o         (wb)
    );

    // big-endian with offset 0 in the top byte
    assign rdata = {mem[{dbus.addr[5:2], 2'd0}], mem[{dbus.addr[5:2], 2'd1}],
                    mem[{dbus.addr[5:2], 2'd2}], mem[{dbus.addr[5:2], 2'd3}]};

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 29 + 91);
    endfunction

    function automatic logic [31:0] gold_word(input logic [31:0] a);
        return {gold[{a[5:2], 2'd0}], gold[{a[5:2], 2'd1}],
                gold[{a[5:2], 2'd2}], gold[{a[5:2], 2'd3}]};
    endfunction

    function automatic logic [31:0] rand_base();
        return $urandom & 32'hffff_fffc;
    endfunction

    function automatic mem_pkg::dbus_req_t ref_bus(input mem_pkg::ex_mem_t e, input logic link);
        mem_pkg::dbus_req_t b;
        int                 off;
        off    = int'(e.addr[1:0]);
        b      = '0;
        b.addr = e.addr;
        b.ce   = (e.op != mem_pkg::OP_NONE);
        for (int k = 0; k < 4; k++) begin   // k is the byte offset of lane 3 - k
            case (e.op)
                mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB: b.sel[3 - k] = (k == off);
                mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH:
                    b.sel[3 - k] = (off % 2 == 0) && (k / 2 == off / 2);
                mem_pkg::OP_LWL, mem_pkg::OP_SWL: b.sel[3 - k] = (k >= off);
                mem_pkg::OP_LWR: b.sel[3 - k] = (k >= 3 - off);
                mem_pkg::OP_SWR: b.sel[3 - k] = (k <= off);
                default: b.sel[3 - k] = 1'b1;
            endcase
        end
        case (e.op)
            mem_pkg::OP_SB: b.wdata = {4{e.rt_val[7:0]}};
            mem_pkg::OP_SH: b.wdata = {2{e.rt_val[15:0]}};
            mem_pkg::OP_SW: b.wdata = e.rt_val;
            mem_pkg::OP_SWL: begin
                b.addr[1:0] = 2'b00;
                b.wdata     = e.rt_val >> (8 * off);
            end
            mem_pkg::OP_SWR: begin
                b.addr[1:0] = 2'b00;
                b.wdata     = e.rt_val << (8 * (3 - off));
            end
            mem_pkg::OP_LWL, mem_pkg::OP_LWR: b.addr[1:0] = 2'b00;
            mem_pkg::OP_SC: begin
                b.ce    = link;
                b.we    = link;
                b.wdata = e.rt_val;
            end
            default: begin
            end
        endcase
        if (e.op inside {mem_pkg::OP_SB, mem_pkg::OP_SH, mem_pkg::OP_SW,
                         mem_pkg::OP_SWL, mem_pkg::OP_SWR}) begin
            b.we = 1'b1;
        end
        return b;
    endfunction

    function automatic mem_pkg::wb_t ref_wb(input mem_pkg::ex_mem_t e,
                                            input logic [31:0] word, input logic link);
        mem_pkg::wb_t w;
        logic [7:0]   mb [4];   // memory bytes by offset
        logic [7:0]   rb [4];   // rt bytes with the top byte first
        logic [15:0]  hw;
        int           off;
        off = int'(e.addr[1:0]);
        for (int j = 0; j < 4; j++) begin
            mb[j] = word[31 - 8 * j -: 8];
            rb[j] = e.rt_val[31 - 8 * j -: 8];
        end
        hw      = (off >= 2) ? {mb[2], mb[3]} : {mb[0], mb[1]};
        w.wd    = e.wd;
        w.wreg  = e.wreg;
        w.wdata = e.alu_res;
        case (e.op)
            mem_pkg::OP_LB:  w.wdata = {{24{mb[off][7]}}, mb[off]};
            mem_pkg::OP_LBU: w.wdata = {24'h0, mb[off]};
            mem_pkg::OP_LH:  w.wdata = (off % 2 != 0) ? 32'h0 : {{16{hw[15]}}, hw};
            mem_pkg::OP_LHU: w.wdata = (off % 2 != 0) ? 32'h0 : {16'h0, hw};
            mem_pkg::OP_LW, mem_pkg::OP_LL: w.wdata = word;
            mem_pkg::OP_LWL: begin
                for (int j = 0; j < 4; j++) begin
                    if (j + off <= 3) begin
                        w.wdata[31 - 8 * j -: 8] = mb[j + off];
                    end else begin
                        w.wdata[31 - 8 * j -: 8] = rb[j];
                    end
                end
            end
            mem_pkg::OP_LWR: begin
                for (int j = 0; j < 4; j++) begin
                    if (j >= 3 - off) begin
                        w.wdata[31 - 8 * j -: 8] = mb[j - 3 + off];
                    end else begin
                        w.wdata[31 - 8 * j -: 8] = rb[j];
                    end
                end
            end
            mem_pkg::OP_SC: w.wdata = {31'h0, link};
            default: begin
            end
        endcase
        return w;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        exp_wb <= exp_wb_pend;
        if (!arst_n) begin
            exp_wb.wreg <= 1'b0;
            link_m      <= 1'b0;
            for (int i = 0; i < 64; i++) begin
                mem[i]  <= fill_byte(i);
                gold[i] <= fill_byte(i);
            end
        end else begin
            if (ex.op == mem_pkg::OP_LL) begin
                link_m <= 1'b1;
            end else if (ex.op == mem_pkg::OP_SC) begin
                link_m <= 1'b0;
            end
            for (int ln = 0; ln < 4; ln++) begin
                if (dbus.ce && dbus.we && dbus.sel[ln]) begin
                    mem[{dbus.addr[5:2], 2'(3 - ln)}] <= dbus.wdata[8 * ln +: 8];
                end
                if (exp_bus.ce && exp_bus.we && exp_bus.sel[ln]) begin
                    gold[{exp_bus.addr[5:2], 2'(3 - ln)}] <= exp_bus.wdata[8 * ln +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("Fail at %0d ns: %s expected 0x%h, got 0x%h", $time, sig, exp_v, act_v);
        $display("Test failed");
        $fatal(1, "mismatch on %s", sig);
    endtask

    // sampled mid-cycle away from both edges
    assert property (@(negedge clk) dbus.ce == exp_bus.ce)
        else report_mismatch("dbus_o.ce", 32'(exp_bus.ce), 32'(dbus.ce));
    assert property (@(negedge clk) dbus.we == exp_bus.we)
        else report_mismatch("dbus_o.we", 32'(exp_bus.we), 32'(dbus.we));
    assert property (@(negedge clk) !exp_bus.ce || dbus.addr == exp_bus.addr)
        else report_mismatch("dbus_o.addr", exp_bus.addr, dbus.addr);
    assert property (@(negedge clk) !exp_bus.ce || dbus.sel == exp_bus.sel)
        else report_mismatch("dbus_o.sel", 32'(exp_bus.sel), 32'(dbus.sel));
    assert property (@(negedge clk) !exp_bus.we || dbus.wdata == exp_bus.wdata)
        else report_mismatch("dbus_o.wdata", exp_bus.wdata, dbus.wdata);
    assert property (@(negedge clk) ex.op != mem_pkg::OP_NONE || (!dbus.ce && !dbus.we))
        else report_mismatch("dbus_o.ce/we on bubble", 32'd0, 32'({dbus.ce, dbus.we}));
    assert property (@(negedge clk) wb.wreg == exp_wb.wreg)
        else report_mismatch("wb_o.wreg", 32'(exp_wb.wreg), 32'(wb.wreg));
    assert property (@(negedge clk) wb.wd == exp_wb.wd)
        else report_mismatch("wb_o.wd", 32'(exp_wb.wd), 32'(wb.wd));
    assert property (@(negedge clk) wb.wdata == exp_wb.wdata)
        else report_mismatch("wb_o.wdata", exp_wb.wdata, wb.wdata);

    task automatic issue(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                         input logic [31:0] rt, input logic wreg);
        @(posedge clk);
        #2;
        ex.op       = op;
        ex.addr     = addr;
        ex.rt_val   = rt;
        ex.wd       = 5'($urandom);
        ex.wreg     = wreg;
        ex.alu_res  = $urandom;
        exp_bus     = ref_bus(ex, link_m);
        exp_wb_pend = ref_wb(ex, gold_word(addr), link_m);
    endtask

    task automatic issue_mem(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] rt);
        issue(op, addr, rt, 1'b1);
    endtask

    initial begin
        logic [31:0]      base;
        mem_pkg::mem_op_e rop;
        void'($urandom(SEED));
        ex          = '0;
        exp_bus     = '0;
        exp_wb_pend = '0;

        // wreg held high while in reset
        repeat (15) issue(mem_pkg::OP_NONE, $urandom, $urandom, 1'b1);
        wait (arst_n);
        repeat (3) issue(mem_pkg::OP_NONE, $urandom, $urandom, 1'b0);

        for (int off = 0; off < 4; off++) begin
            base = rand_base();
            issue_mem(mem_pkg::OP_SW, base, $urandom);
            issue_mem(mem_pkg::OP_SB, base | 32'(off), $urandom);
            issue_mem(mem_pkg::OP_LW, base, $urandom);
            issue_mem(mem_pkg::OP_SW, base, $urandom);
            issue_mem(mem_pkg::OP_SH, base | 32'(off), $urandom);
            issue_mem(mem_pkg::OP_LW, base, $urandom);
        end

        for (int off = 0; off < 4; off++) begin
            base = rand_base();
            issue_mem(mem_pkg::OP_SW, base, $urandom);
            issue_mem(mem_pkg::OP_LB, base | 32'(off), $urandom);
            issue_mem(mem_pkg::OP_LBU, base | 32'(off), $urandom);
            issue_mem(mem_pkg::OP_LH, base | 32'(off), $urandom);
            issue_mem(mem_pkg::OP_LHU, base | 32'(off), $urandom);
        end

        for (int off = 0; off < 4; off++) begin
            base = rand_base();
            issue_mem(mem_pkg::OP_SW, base, $urandom);
            issue_mem(mem_pkg::OP_LWL, base | 32'(off), $urandom);
            issue_mem(mem_pkg::OP_LWR, base | 32'(off), $urandom);
            issue_mem(mem_pkg::OP_SWL, base | 32'(off), $urandom);
            issue_mem(mem_pkg::OP_LW, base, $urandom);
            issue_mem(mem_pkg::OP_SW, base, $urandom);
            issue_mem(mem_pkg::OP_SWR, base | 32'(off), $urandom);
            issue_mem(mem_pkg::OP_LW, base, $urandom);
        end

        // second SC must fail and leave the word alone
        base = rand_base();
        issue_mem(mem_pkg::OP_SW, base, $urandom);
        issue_mem(mem_pkg::OP_LL, base, $urandom);
        issue_mem(mem_pkg::OP_SC, base, $urandom);
        issue_mem(mem_pkg::OP_LW, base, $urandom);
        issue_mem(mem_pkg::OP_SC, base, $urandom);
        issue_mem(mem_pkg::OP_LW, base, $urandom);

        repeat (80) begin
            rop = mem_pkg::mem_op_e'(5'($urandom_range(14, 0)));
            issue_mem(rop, $urandom, $urandom);
        end

        repeat (2) issue(mem_pkg::OP_NONE, $urandom, $urandom, 1'b0);
        @(negedge clk);
        #1;
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* test/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release just after the last reset edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_stage (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  mem_pkg::ex_mem_t        ex_i,
    input  logic [`MEM_WORD_W-1:0]  dbus_rdata_i,
    output mem_pkg::dbus_req_t      dbus_o,
    output mem_pkg::wb_t            wb_o
);

    logic         sc_ok;
    mem_pkg::wb_t wb_comb;   // aligned result before MEM/WB

    link_bit u_link_bit (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .op_i     (ex_i.op),
        .sc_ok_o  (sc_ok)
    );

    mem_access_ctrl u_mem_access_ctrl (
        .ex_i    (ex_i),
        .sc_ok_i (sc_ok),
        .dbus_o  (dbus_o)
    );

    load_align u_load_align (
        .ex_i    (ex_i),
        .rdata_i (dbus_rdata_i),
        .sc_ok_i (sc_ok),
        .wb_o    (wb_comb)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_i     (wb_comb),
        .wb_o     (wb_o)
    );

endmodule

`default_nettype wire

/* verilog/mem_wb_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_wb_reg (
    input  logic          clk,
    input  logic          arst_n_i,
    input  mem_pkg::wb_t  wb_i,
    output mem_pkg::wb_t  wb_o
);

    logic                      wreg_q;
    logic [`MEM_REGADDR_W-1:0] wd_q;
    logic [`MEM_WORD_W-1:0]    wdata_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wreg_q <= 1'b0;
        end else begin
            wreg_q <= wb_i.wreg;
        end
    end

    always_ff @(posedge clk) begin
        wd_q    <= wb_i.wd;
        wdata_q <= wb_i.wdata;
    end

    assign wb_o.wd    = wd_q;
    assign wb_o.wreg  = wreg_q;
    assign wb_o.wdata = wdata_q;

endmodule

`default_nettype wire

/* verilog/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module load_align (
    input  mem_pkg::ex_mem_t        ex_i,
    input  logic [`MEM_WORD_W-1:0]  rdata_i,
    input  logic                    sc_ok_i,
    output mem_pkg::wb_t            wb_o
);

    localparam logic [`MEM_WORD_W-1:0] ONES = '1;

    logic [1:0]             off;
    logic [4:0]             lo_shamt;
    logic [4:0]             hi_shamt;
    logic [7:0]             lane_byte;
    logic [15:0]            lane_half;
    logic [`MEM_WORD_W-1:0] lwl_word;
    logic [`MEM_WORD_W-1:0] lwr_word;

    assign off      = ex_i.addr[1:0];
    assign lo_shamt = {off, 3'b000};
    assign hi_shamt = {~off, 3'b000};

    // big-endian so offset 0 sits in bits 31:24
    assign lane_byte = 8'(rdata_i >> hi_shamt);
    assign lane_half = off[1] ? rdata_i[15:0] : rdata_i[31:16];

    // memory bytes from offset on with low rt bytes kept
    assign lwl_word = (rdata_i << lo_shamt) | (ex_i.rt_val & ~(ONES << lo_shamt));
    // memory bytes up to offset with high rt bytes kept
    assign lwr_word = (rdata_i >> hi_shamt) | (ex_i.rt_val & ~(ONES >> hi_shamt));

    always_comb begin
        wb_o.wd    = ex_i.wd;
        wb_o.wreg  = ex_i.wreg;
        wb_o.wdata = ex_i.alu_res;        // bubbles and stores

        case (ex_i.op)
            mem_pkg::OP_LB: begin
                wb_o.wdata = {{24{lane_byte[7]}}, lane_byte};
            end
            mem_pkg::OP_LBU: begin
                wb_o.wdata = {24'b0, lane_byte};
            end
            mem_pkg::OP_LH: begin
                wb_o.wdata = off[0] ? '0 : {{16{lane_half[15]}}, lane_half};
            end
            mem_pkg::OP_LHU: begin
                wb_o.wdata = off[0] ? '0 : {16'b0, lane_half};
            end
            mem_pkg::OP_LW, mem_pkg::OP_LL: begin
                wb_o.wdata = rdata_i;
            end
            mem_pkg::OP_LWL: begin
                wb_o.wdata = lwl_word;
            end
            mem_pkg::OP_LWR: begin
                wb_o.wdata = lwr_word;
            end
            mem_pkg::OP_SC: begin
                wb_o.wdata = {{(`MEM_WORD_W-1){1'b0}}, sc_ok_i}; // 1 on success
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mem_access_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_access_ctrl (
    input  mem_pkg::ex_mem_t   ex_i,
    input  logic               sc_ok_i,
    output mem_pkg::dbus_req_t dbus_o
);

    localparam logic [`MEM_SEL_W-1:0] ALL_LANES = '1;

    logic [1:0]                   off;
    logic [4:0]                   lo_shamt;
    logic [4:0]                   hi_shamt;
    logic [`MEM_WORD_W-1:0]       word_addr;

    assign off       = ex_i.addr[1:0];
    assign lo_shamt  = {off, 3'b000};      // 8 * off
    assign hi_shamt  = {~off, 3'b000};     // 8 * (3 - off)
    assign word_addr = {ex_i.addr[`MEM_WORD_W-1:2], 2'b00};

    always_comb begin
        dbus_o.ce    = 1'b0;
        dbus_o.we    = 1'b0;
        dbus_o.addr  = ex_i.addr;
        dbus_o.sel   = '0;
        dbus_o.wdata = '0;

        case (ex_i.op)
            mem_pkg::OP_LB, mem_pkg::OP_LBU: begin
                dbus_o.ce  = 1'b1;
                dbus_o.sel = 4'b1000 >> off;    // one lane per offset
            end
            mem_pkg::OP_LH, mem_pkg::OP_LHU: begin
                dbus_o.ce = 1'b1;
                if (!off[0]) begin
                    dbus_o.sel = off[1] ? 4'b0011 : 4'b1100;
                end
            end
            mem_pkg::OP_LW, mem_pkg::OP_LL: begin
                dbus_o.ce  = 1'b1;
                dbus_o.sel = ALL_LANES;
            end
            mem_pkg::OP_LWL: begin
                dbus_o.ce   = 1'b1;
                dbus_o.addr = word_addr;
                dbus_o.sel  = ALL_LANES >> off;
            end
            mem_pkg::OP_LWR: begin
                dbus_o.ce   = 1'b1;
                dbus_o.addr = word_addr;
                dbus_o.sel  = ALL_LANES >> (2'd3 - off);
            end
            mem_pkg::OP_SB: begin
                dbus_o.ce    = 1'b1;
                dbus_o.we    = 1'b1;
                dbus_o.sel   = 4'b1000 >> off;
                dbus_o.wdata = {4{ex_i.rt_val[7:0]}};
            end
            mem_pkg::OP_SH: begin
                dbus_o.ce    = 1'b1;
                dbus_o.we    = 1'b1;
                dbus_o.wdata = {2{ex_i.rt_val[15:0]}};
                if (!off[0]) begin
                    dbus_o.sel = off[1] ? 4'b0011 : 4'b1100;
                end
            end
            mem_pkg::OP_SW: begin
                dbus_o.ce    = 1'b1;
                dbus_o.we    = 1'b1;
                dbus_o.sel   = ALL_LANES;
                dbus_o.wdata = ex_i.rt_val;
            end
            mem_pkg::OP_SWL: begin
                dbus_o.ce    = 1'b1;
                dbus_o.we    = 1'b1;
                dbus_o.addr  = word_addr;
                dbus_o.sel   = ALL_LANES >> off;
                dbus_o.wdata = ex_i.rt_val >> lo_shamt; // high bytes go low
            end
            mem_pkg::OP_SWR: begin
                dbus_o.ce    = 1'b1;
                dbus_o.we    = 1'b1;
                dbus_o.addr  = word_addr;
                dbus_o.sel   = ALL_LANES << (2'd3 - off);
                dbus_o.wdata = ex_i.rt_val << hi_shamt; // low bytes go high
            end
            mem_pkg::OP_SC: begin
                // failed SC leaves the bus idle
                dbus_o.ce    = sc_ok_i;
                dbus_o.we    = sc_ok_i;
                dbus_o.sel   = ALL_LANES;
                dbus_o.wdata = ex_i.rt_val;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/link_bit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module link_bit (
    input  logic              clk,
    input  logic              arst_n_i,
    input  mem_pkg::mem_op_e  op_i,
    output logic              sc_ok_o
);

    logic ll_q;

    // set by LL, consumed by SC whether it succeeds or not
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ll_q <= 1'b0;
        end else if (op_i == mem_pkg::OP_LL) begin
            ll_q <= 1'b1;
        end else if (op_i == mem_pkg::OP_SC) begin
            ll_q <= 1'b0;
        end
    end

    assign sc_ok_o = (op_i == mem_pkg::OP_SC) && ll_q; // only meaningful for SC

endmodule

`default_nettype wire

/* verilog/mem_pkg.sv */
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

    typedef enum logic [`MEM_OP_W-1:0] {
        OP_NONE,               // bubble
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_LWL,
        OP_LWR,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_SWL,
        OP_SWR,
        OP_LL,
        OP_SC
    } mem_op_e;

    typedef struct packed {
        mem_op_e                   op;
        logic [`MEM_WORD_W-1:0]    addr;      // effective address
        logic [`MEM_WORD_W-1:0]    rt_val;    // store data / merge source
        logic [`MEM_REGADDR_W-1:0] wd;
        logic                      wreg;
        logic [`MEM_WORD_W-1:0]    alu_res;   // non-memory result
    } ex_mem_t;

    typedef struct packed {
        logic                   ce;
        logic                   we;
        logic [`MEM_WORD_W-1:0] addr;
        logic [`MEM_SEL_W-1:0]  sel;          // lane 3 = offset 0
        logic [`MEM_WORD_W-1:0] wdata;
    } dbus_req_t;

    typedef struct packed {
        logic [`MEM_REGADDR_W-1:0] wd;
        logic                      wreg;
        logic [`MEM_WORD_W-1:0]    wdata;
    } wb_t;

endpackage

`default_nettype wire

/* verilog/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data bus and address width
`define MEM_WORD_W    32

// register file index
`define MEM_REGADDR_W 5

// byte lanes per word
`define MEM_SEL_W     4

// operation enum width
`define MEM_OP_W      5

`endif
